/* verilog.f */
+incdir+source
source/softmax_pkg.sv
source/softmax_ctrl.sv
source/row_buffer.sv
source/max_tree.sv
source/norm_exp_lanes.sv
source/sum_tree.sv
source/softmax_top.sv
dv/softmax_asserts.sv
dv/softmax_tb.sv

/* run.sh */
#!/bin/sh
# build and run the softmax testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module softmax_tb -o softmax_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/softmax_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

/* dv/softmax_tb.sv */
`timescale 1ns/1ps
`include "softmax_consts.svh"

module softmax_tb;
  import softmax_pkg::*;

  localparam int TOTAL_ROWS      = 64;
  localparam int RUNS            = 6;
  localparam int RUN_OVERHEAD    = 24;
  localparam int WATCHDOG_CYCLES = 8 + 2 * TOTAL_ROWS + RUNS * RUN_OVERHEAD + 200;

  logic     clk;
  logic     reset;
  logic     init;
  logic     start;
  addr_t    start_addr;
  addr_t    end_addr;
  row_t     inp;
  addr_t    addr;
  row_t     norm_row;
  exp_row_t exp_row;
  logic     out_valid;
  sum_t     sum;
  logic     done;

  row_t        mem [64];
  logic [15:0] lfsr_state;
  int          mismatches;
  int          failures;

  softmax_top dut0 (
    .clk        (clk),
    .reset      (reset),
    .init       (init),
    .start      (start),
    .start_addr (start_addr),
    .end_addr   (end_addr),
    .inp        (inp),
    .addr       (addr),
    .norm_row   (norm_row),
    .exp_row    (exp_row),
    .out_valid  (out_valid),
    .sum        (sum),
    .done       (done)
  );

  // memory answers in the same cycle
  assign inp = mem[addr];

  always #5 clk = ~clk;

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int nbits, output logic [15:0] val);
    val = '0;
    for (int b = 0; b < nbits; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[14:0], lfsr_state[0]};
    end
  endtask

  function automatic int lane_of(input row_t r, input int i);
    logic [63:0] bits;
    bits = r;
    return int'($signed(bits[16*i +: 16]));
  endfunction

  function automatic int row_max(input int base, input int n);
    int m;
    m = lane_of(mem[base], 0);
    for (int a = base; a < base + n; a++) begin
      for (int i = 0; i < `SM_LANES; i++) begin
        if (lane_of(mem[a], i) > m) m = lane_of(mem[a], i);
      end
    end
    return m;
  endfunction

  // value minus max clamped at -128.0
  function automatic int norm_of(input int v, input int m);
    int d;
    d = v - m;
    if (d < -32768) d = -32768;
    return d;
  endfunction

  function automatic int exp_of(input int d);
    int k;
    k = ((d < 0) ? -d : d) >> `SM_FRAC_BITS;
    if (k >= 9) return 0;
    return `SM_EXP_ONE >> k;
  endfunction

  task automatic set_row(input int a, input int l0, input int l1, input int l2, input int l3);
    mem[a] = {16'(l3), 16'(l2), 16'(l1), 16'(l0)};
  endtask

  task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      mismatches++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("%0t: %s", $time, what);
    failures++;
  endtask

  // one full pass; poke fires init and start again mid run
  task automatic run_rows(input string name, input int base, input int n, input bit poke);
    int          m;
    int          cycles;
    int          seen;
    int          last_seen;
    int          want_sum;
    int          d;
    logic [63:0] want_norm;
    logic [63:0] want_exp;
    m = row_max(base, n);
    want_sum = 0;
    seen = 0;
    last_seen = 0;
    @(negedge clk);
    init = 1'b1;
    start_addr = addr_t'(base);
    @(negedge clk);
    init = 1'b0;
    start = 1'b1;
    end_addr = addr_t'(base + n);
    @(negedge clk);
    start = 1'b0;
    cycles = 1;
    while (!done && cycles <= 2 * n + RUN_OVERHEAD) begin
      // load pass walks the memory once
      if (cycles <= n) begin
        check($sformatf("%s addr %0d", name, cycles), 64'(base + cycles - 1), 64'(addr));
      end
      if (out_valid) begin
        if (seen == 0) check({name, " first out_valid cycle"}, 64'(n + 4), 64'(cycles));
        for (int i = 0; i < `SM_LANES; i++) begin
          d = norm_of(lane_of(mem[base + seen], i), m);
          want_norm[16*i +: 16] = 16'(d);
          want_exp[16*i +: 16] = 16'(exp_of(d));
          want_sum += exp_of(d);
        end
        check($sformatf("%s row %0d norm_row", name, seen), want_norm, norm_row);
        check($sformatf("%s row %0d exp_row", name, seen), want_exp, exp_row);
        seen++;
        last_seen = cycles;
      end
      init = poke && (cycles == 4);
      start = poke && (cycles == 4);
      if (poke && cycles == 4) start_addr = addr_t'(base + 9);
      @(negedge clk);
      cycles++;
    end
    init = 1'b0;
    start = 1'b0;
    if (!done) begin
      report_failure($sformatf("%s: done never pulsed", name));
    end else begin
      if (seen != n) report_failure($sformatf("%s: %0d output rows, %0d expected", name, seen, n));
      check({name, " done delay"}, 64'(3), 64'(cycles - last_seen));
      check({name, " sum"}, 64'(want_sum), 64'(sum));
    end
    // sum must hold and no second done
    repeat (4) begin
      @(negedge clk);
      if (done || out_valid) report_failure($sformatf("%s: activity after done", name));
      check({name, " sum hold"}, 64'(want_sum), 64'(sum));
    end
  endtask

  task automatic reset_values_test();
    check("reset addr", 64'(0), 64'(addr));
    check("reset norm_row", 64'(0), 64'(norm_row));
    check("reset exp_row", 64'(0), 64'(exp_row));
    check("reset out_valid", 64'(0), 64'(out_valid));
    check("reset sum", 64'(0), 64'(sum));
    check("reset done", 64'(0), 64'(done));
  endtask

  task automatic one_row_test();
    set_row(0, 384, -576, 768, 192);
    run_rows("one_row", 0, 1, 1'b0);
  endtask

  task automatic late_max_test();
    for (int r = 0; r < 8; r++) set_row(8 + r, r * 32, -r * 48, 100 - r, r * 16);
    set_row(15, 224, -336, 2560, 112);
    run_rows("late_max", 8, 8, 1'b0);
  endtask

  task automatic saturation_test();
    set_row(56, -32768, 32767, 0, 16384);
    set_row(57, -2176, 32512, -256, 30720);
    // k of 8 and 9 against the max
    set_row(58, 30591, 30463, -256, 32766);
    run_rows("saturation", 56, 3, 1'b0);
  endtask

  task automatic random_test();
    logic [15:0] bits;
    int          v [4];
    for (int r = 0; r < 40; r++) begin
      for (int i = 0; i < 4; i++) begin
        rand_bits(12, bits);
        v[i] = int'($signed(bits[11:0]));
      end
      set_row(16 + r, v[0], v[1], v[2], v[3]);
    end
    run_rows("random", 16, 40, 1'b0);
  endtask

  task automatic back_to_back_test();
    run_rows("back_to_back_a", 2, 5, 1'b0);
    run_rows("back_to_back_b", 20, 7, 1'b1);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    init = 1'b0;
    start = 1'b0;
    start_addr = '0;
    end_addr = '0;
    lfsr_state = 16'd39;
    mismatches = 0;
    failures = 0;
    for (int a = 0; a < 64; a++) mem[a] = {4{16'(a * 37)}};
    repeat (8) @(negedge clk);
    reset = 1'b0;
    reset_values_test();
    one_row_test();
    late_max_test();
    saturation_test();
    random_test();
    back_to_back_test();
    $display("mismatches %0d, other failures %0d", mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

/* dv/softmax_asserts.sv */
`timescale 1ns/1ps
`include "softmax_consts.svh"

module softmax_asserts (
  input logic                  clk,
  input logic                  reset,
  input logic                  done,
  input logic                  out_valid,
  input logic                  load_valid,
  input softmax_pkg::exp_row_t exp_row
);

  done_is_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else $error("done stayed high for more than one cycle");

  // results only come out of the replay pass
  no_output_while_loading: assert property (@(posedge clk) disable iff (reset)
    load_valid |-> !out_valid)
    else $error("out_valid high during the load phase");

  exp_in_range: assert property (@(posedge clk) disable iff (reset)
    exp_row.lane0 <= 16'(`SM_EXP_ONE) && exp_row.lane1 <= 16'(`SM_EXP_ONE) &&
    exp_row.lane2 <= 16'(`SM_EXP_ONE) && exp_row.lane3 <= 16'(`SM_EXP_ONE))
    else $error("exponent lane above 1.0");

endmodule

bind softmax_top softmax_asserts asserts0 (
  .clk        (clk),
  .reset      (reset),
  .done       (done),
  .out_valid  (out_valid),
  .load_valid (ctl.load_valid),
  .exp_row    (exp_row)
);

/* source/softmax_top.sv */
`timescale 1ns/1ps

module softmax_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  init,
  input  logic                  start,
  input  softmax_pkg::addr_t    start_addr,
  input  softmax_pkg::addr_t    end_addr,
  input  softmax_pkg::row_t     inp,
  output softmax_pkg::addr_t    addr,
  output softmax_pkg::row_t     norm_row,
  output softmax_pkg::exp_row_t exp_row,
  output logic                  out_valid,
  output softmax_pkg::sum_t     sum,
  output logic                  done
);
  import softmax_pkg::*;

  addr_t     rd_addr;
  pipe_ctl_t ctl;
  row_t      rd_row;
  elem_t     row_max;
  logic      rd_valid;
  logic      sum_valid;
  logic      sum_clear;

  softmax_ctrl ctrl0 (
    .clk        (clk),
    .reset      (reset),
    .init       (init),
    .start      (start),
    .start_addr (start_addr),
    .end_addr   (end_addr),
    .addr       (addr),
    .rd_addr    (rd_addr),
    .ctl        (ctl),
    .rd_valid   (rd_valid),
    .out_valid  (out_valid),
    .sum_valid  (sum_valid),
    .sum_clear  (sum_clear),
    .done       (done)
  );

  // rows are written as they stream in from memory
  row_buffer buf0 (
    .clk     (clk),
    .wr_en   (ctl.load_valid),
    .wr_addr (addr),
    .wr_row  (inp),
    .rd_addr (rd_addr),
    .rd_row  (rd_row)
  );

  max_tree max0 (
    .clk   (clk),
    .reset (reset),
    .row   (inp),
    .valid (ctl.load_valid),
    .clear (ctl.max_clear),
    .max   (row_max)
  );

  norm_exp_lanes lanes0 (
    .clk      (clk),
    .reset    (reset),
    .valid    (rd_valid),
    .row      (rd_row),
    .max      (row_max),
    .norm_row (norm_row),
    .exp_row  (exp_row)
  );

  sum_tree sum0 (
    .clk     (clk),
    .reset   (reset),
    .exp_row (exp_row),
    .valid   (sum_valid),
    .clear   (sum_clear),
    .sum     (sum)
  );

endmodule

/* source/sum_tree.sv */
`timescale 1ns/1ps
`include "softmax_consts.svh"

module sum_tree (
  input  logic                  clk,
  input  logic                  reset,
  input  softmax_pkg::exp_row_t exp_row,
  input  logic                  valid,
  input  logic                  clear,
  output softmax_pkg::sum_t     sum
);
  import softmax_pkg::*;

  localparam int PAIR_W  = `SM_ELEM_W + 1;
  localparam int TOTAL_W = `SM_ELEM_W + 2;

  logic [PAIR_W-1:0]  pair0_q;
  logic [PAIR_W-1:0]  pair1_q;
  logic [TOTAL_W-1:0] total_q;

  // first level, lanes in pairs
  always_ff @(posedge clk) begin
    pair0_q <= PAIR_W'(exp_row.lane0) + PAIR_W'(exp_row.lane1);
    pair1_q <= PAIR_W'(exp_row.lane2) + PAIR_W'(exp_row.lane3);
  end

  // second level, row total
  always_ff @(posedge clk) begin
    total_q <= TOTAL_W'(pair0_q) + TOTAL_W'(pair1_q);
  end

  // accumulator, several rows may be in the tree at once
  always_ff @(posedge clk) begin
    if (reset) begin
      sum <= '0;
    end else if (clear) begin
      sum <= '0;
    end else if (valid) begin
      sum <= sum + sum_t'(total_q);
    end
  end

endmodule

/* source/norm_exp_lanes.sv */
`timescale 1ns/1ps
`include "softmax_consts.svh"

module norm_exp_lanes (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  valid,
  input  softmax_pkg::row_t     row,
  input  softmax_pkg::elem_t    max,
  output softmax_pkg::row_t     norm_row,
  output softmax_pkg::exp_row_t exp_row
);
  import softmax_pkg::*;

  localparam int WIDE_W = `SM_ELEM_W + 1;

  elem_t [`SM_LANES-1:0] in_lanes;
  elem_t [`SM_LANES-1:0] diff_d;
  elem_t [`SM_LANES-1:0] diff_q;
  exp_t  [`SM_LANES-1:0] exp_d;
  logic                  s1_valid;

  // a - b clamped to the elem_t range
  function automatic elem_t sat_sub(elem_t a, elem_t b);
    logic signed [WIDE_W-1:0] wide;
    wide = WIDE_W'(a) - WIDE_W'(b);
    if (wide[WIDE_W-1] == wide[WIDE_W-2]) begin
      return elem_t'(wide);
    end else if (wide[WIDE_W-1]) begin
      return {1'b1, {(`SM_ELEM_W-1){1'b0}}};
    end else begin
      return {1'b0, {(`SM_ELEM_W-1){1'b1}}};
    end
  endfunction

  // 2^-k with k the integer part of |d|
  function automatic exp_t exp_approx(elem_t d);
    logic signed [WIDE_W-1:0] wide;
    logic        [WIDE_W-1:0] mag;
    logic        [WIDE_W-1:0] k;
    wide = WIDE_W'(d);
    mag  = (wide < 0) ? -wide : wide;
    k    = mag >> `SM_FRAC_BITS;
    if (k > `SM_FRAC_BITS) begin
      return '0;
    end
    return exp_t'(`SM_EXP_ONE) >> k[3:0];
  endfunction

  assign in_lanes = row;

  always_comb begin
    for (int i = 0; i < `SM_LANES; i++) begin
      diff_d[i] = sat_sub(in_lanes[i], max);
      exp_d[i]  = exp_approx(diff_q[i]);
    end
  end

  // stage 1 difference
  always_ff @(posedge clk) begin
    if (valid) begin
      diff_q <= diff_d;
    end
  end

  // stage 2 exponent, normalized row alongside
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      norm_row <= '0;
      exp_row  <= '0;
    end else begin
      s1_valid <= valid;
      if (s1_valid) begin
        norm_row <= row_t'(diff_q);
        exp_row  <= exp_row_t'(exp_d);
      end
    end
  end

endmodule

/* source/max_tree.sv */
`timescale 1ns/1ps

module max_tree (
  input  logic               clk,
  input  logic               reset,
  input  softmax_pkg::row_t  row,
  input  logic               valid,
  input  logic               clear,
  output softmax_pkg::elem_t max
);
  import softmax_pkg::*;

  elem_t max_01;
  elem_t max_23;
  elem_t row_max;
  elem_t next_max;

  function automatic elem_t pick_max(elem_t a, elem_t b);
    return (a > b) ? a : b;
  endfunction

  // two compare levels across the lanes
  assign max_01  = pick_max(row.lane0, row.lane1);
  assign max_23  = pick_max(row.lane2, row.lane3);
  assign row_max = pick_max(max_01, max_23);

  // first row of a run ignores the old max
  assign next_max = clear ? row_max : pick_max(max, row_max);

  always_ff @(posedge clk) begin
    if (reset) begin
      max <= '0;
    end else if (valid) begin
      max <= next_max;
    end
  end

endmodule

/* source/row_buffer.sv */
`timescale 1ns/1ps
`include "softmax_consts.svh"

module row_buffer (
  input  logic               clk,
  input  logic               wr_en,
  input  softmax_pkg::addr_t wr_addr,
  input  softmax_pkg::row_t  wr_row,
  input  softmax_pkg::addr_t rd_addr,
  output softmax_pkg::row_t  rd_row
);
  import softmax_pkg::*;

  localparam int DEPTH = 1 << `SM_ADDR_W;

  // holds the rows for the second pass
  row_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_row;
    end
  end

  // registered read, one cycle
  always_ff @(posedge clk) begin
    rd_row <= mem[rd_addr];
  end

endmodule

/* source/softmax_ctrl.sv */
`timescale 1ns/1ps

module softmax_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   init,
  input  logic                   start,
  input  softmax_pkg::addr_t     start_addr,
  input  softmax_pkg::addr_t     end_addr,
  output softmax_pkg::addr_t     addr,
  output softmax_pkg::addr_t     rd_addr,
  output softmax_pkg::pipe_ctl_t ctl,
  output logic                   rd_valid,
  output logic                   out_valid,
  output logic                   sum_valid,
  output logic                   sum_clear,
  output logic                   done
);
  import softmax_pkg::*;

  addr_t      base_addr;
  addr_t      last_addr;
  logic       busy;
  logic       loading;
  logic       replaying;
  logic [4:0] vld_pipe;
  logic [5:0] last_pipe;

  // start only counts when idle
  assign sum_clear = start && !busy;

  always_comb begin
    ctl.load_valid   = loading;
    ctl.max_clear    = loading && (addr == base_addr);
    ctl.replay_valid = replaying;
    ctl.last_row     = replaying && (rd_addr == last_addr);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      loading   <= 1'b0;
      replaying <= 1'b0;
      addr      <= '0;
      rd_addr   <= '0;
      base_addr <= '0;
      last_addr <= '0;
    end else begin
      if (init && !busy) begin
        addr      <= start_addr;
        base_addr <= start_addr;
      end

      if (sum_clear) begin
        busy      <= 1'b1;
        loading   <= 1'b1;
        last_addr <= end_addr - addr_t'(1);
      end

      // load pass, one memory row per cycle
      if (loading) begin
        if (addr == last_addr) begin
          loading   <= 1'b0;
          replaying <= 1'b1;
          addr      <= base_addr;
          rd_addr   <= base_addr;
        end else begin
          addr <= addr + addr_t'(1);
        end
      end

      // replay starts the cycle the max settles
      if (replaying) begin
        if (ctl.last_row) begin
          replaying <= 1'b0;
        end else begin
          rd_addr <= rd_addr + addr_t'(1);
        end
      end

      if (done) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_pipe  <= '0;
      last_pipe <= '0;
    end else begin
      vld_pipe  <= {vld_pipe[3:0], ctl.replay_valid};
      last_pipe <= {last_pipe[4:0], ctl.last_row};
    end
  end

  // buffer read 1, lanes 2, adder tree 2, accumulate 1
  assign rd_valid  = vld_pipe[0];
  assign out_valid = vld_pipe[2];
  assign sum_valid = vld_pipe[4];
  assign done      = last_pipe[5];

endmodule

/* source/softmax_pkg.sv */
`include "softmax_consts.svh"

package softmax_pkg;

  // signed q8.8 lane value
  typedef logic signed [`SM_ELEM_W-1:0] elem_t;

  // lane0 sits in the low bits
  typedef struct packed {
    elem_t lane3;
    elem_t lane2;
    elem_t lane1;
    elem_t lane0;
  } row_t;

  // unsigned q8.8, at most 1.0
  typedef logic [`SM_ELEM_W-1:0] exp_t;

  typedef struct packed {
    exp_t lane3;
    exp_t lane2;
    exp_t lane1;
    exp_t lane0;
  } exp_row_t;

  typedef logic [`SM_SUM_W-1:0] sum_t;

  typedef logic [`SM_ADDR_W-1:0] addr_t;

  typedef struct packed {
    logic load_valid;
    logic max_clear;
    logic replay_valid;
    logic last_row;
  } pipe_ctl_t;

endpackage

/* source/softmax_consts.svh */
`ifndef SOFTMAX_CONSTS_SVH
`define SOFTMAX_CONSTS_SVH

// row geometry
`define SM_LANES     4
`define SM_ELEM_W    16
`define SM_FRAC_BITS 8

// buffer and accumulator sizes
`define SM_ADDR_W    6
`define SM_SUM_W     24

// 1.0 in q8.8
`define SM_EXP_ONE   256

`endif
